// File: Bender.yml
package:
  name: per2axi

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/per2axi_axi_pkg.sv
      - design/per2axi_per_pkg.sv
      - design/per2axi_stream_fifo.sv
      - design/per2axi_req_channel.sv
      - design/per2axi_res_channel.sv
      - design/per2axi_busy_unit.sv
      - design/per2axi_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_per2axi_top.sv

// File: design/per2axi_axi_pkg.sv
`include "per2axi_config.svh"

package per2axi_axi_pkg;

  // ========================================================================
  // Field types
  // ========================================================================

  typedef logic [`PER2AXI_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`PER2AXI_DATA_WIDTH-1:0]   data_t;
  typedef logic [`PER2AXI_DATA_WIDTH/8-1:0] strb_t;   // One per byte lane
  typedef logic [`PER2AXI_AXI_ID_WIDTH-1:0] axi_id_t;

  // ========================================================================
  // Channel payloads
  // ========================================================================

  // Shared by AR and AW
  typedef struct packed {
    addr_t   addr;
    axi_id_t id;
  } ax_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    data_t   data;
    axi_id_t id;
    logic    last;
  } r_chan_t;

  typedef struct packed {
    axi_id_t id;
  } b_chan_t;

endpackage

// File: design/per2axi_busy_unit.sv
`timescale 1ns/1ps

`include "per2axi_config.svh"

module per2axi_busy_unit (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic aw_sync_i,
  input  logic b_sync_i,
  input  logic ar_sync_i,
  input  logic r_sync_i,
  output logic busy_o
);

  logic [`PER2AXI_CNT_WIDTH-1:0] aw_cnt_q;
  logic [`PER2AXI_CNT_WIDTH-1:0] ar_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_cnt_q <= '0;
      ar_cnt_q <= '0;
    end else begin
      case ({aw_sync_i, b_sync_i})
        2'b10:   aw_cnt_q <= aw_cnt_q + 1'b1;
        2'b01:   aw_cnt_q <= aw_cnt_q - 1'b1;
        default: aw_cnt_q <= aw_cnt_q;    // Issue and retire cancel
      endcase
      case ({ar_sync_i, r_sync_i})
        2'b10:   ar_cnt_q <= ar_cnt_q + 1'b1;
        2'b01:   ar_cnt_q <= ar_cnt_q - 1'b1;
        default: ar_cnt_q <= ar_cnt_q;
      endcase
    end
  end

  assign busy_o = (aw_cnt_q != '0) | (ar_cnt_q != '0);

endmodule

// File: design/per2axi_config.svh
`ifndef PER2AXI_CONFIG_SVH
`define PER2AXI_CONFIG_SVH

// ==========================================================================
// Bus widths
// ==========================================================================

`define PER2AXI_ADDR_WIDTH    32
`define PER2AXI_DATA_WIDTH    64
`define PER2AXI_AXI_ID_WIDTH  3
`define PER2AXI_PER_ID_WIDTH  5

// ==========================================================================
// Buffering
// ==========================================================================

`define PER2AXI_REQ_BUF_DEPTH 4   // AR, AW and W
`define PER2AXI_RSP_BUF_DEPTH 2   // R and B
`define PER2AXI_CNT_WIDTH     4   // Outstanding per direction

`endif

// File: design/per2axi_per_pkg.sv
`include "per2axi_config.svh"

package per2axi_per_pkg;

  // ========================================================================
  // Peripheral port
  // ========================================================================

  typedef logic [`PER2AXI_PER_ID_WIDTH-1:0] per_id_t;

  // Encoding of the active-low write enable
  localparam logic PER_WEN_WRITE = 1'b0;
  localparam logic PER_WEN_READ  = 1'b1;

endpackage

// File: design/per2axi_req_channel.sv
`timescale 1ns/1ps

module per2axi_req_channel
  import per2axi_axi_pkg::*;
  import per2axi_per_pkg::*;
(
  input  logic     per_req_i,
  input  addr_t    per_add_i,
  input  logic     per_wen_i,
  input  data_t    per_wdata_i,
  input  strb_t    per_be_i,
  input  per_id_t  per_id_i,
  output logic     per_gnt_o,

  output logic     aw_valid_o,
  output ax_chan_t aw_o,
  input  logic     aw_ready_i,

  output logic     ar_valid_o,
  output ax_chan_t ar_o,
  input  logic     ar_ready_i,

  output logic     w_valid_o,
  output w_chan_t  w_o,
  input  logic     w_ready_i
);

  logic    is_write;
  logic    is_read;
  axi_id_t axi_id;

  assign is_write = per_req_i & (per_wen_i == PER_WEN_WRITE);
  assign is_read  = per_req_i & (per_wen_i == PER_WEN_READ);

  // Grant only with room in every queue
  assign per_gnt_o = aw_ready_i & ar_ready_i & w_ready_i;

  // AW and W always go together
  assign aw_valid_o = is_write & aw_ready_i & w_ready_i;
  assign w_valid_o  = is_write & aw_ready_i & w_ready_i;
  assign ar_valid_o = is_read & ar_ready_i;

  assign axi_id = axi_id_t'(per_id_i);  // Upper ID bits dropped

  assign aw_o.addr = per_add_i;
  assign aw_o.id   = axi_id;
  assign ar_o.addr = per_add_i;
  assign ar_o.id   = axi_id;
  assign w_o.data  = per_wdata_i;
  assign w_o.strb  = per_be_i;

endmodule

// File: design/per2axi_res_channel.sv
`timescale 1ns/1ps

module per2axi_res_channel
  import per2axi_axi_pkg::*;
  import per2axi_per_pkg::*;
(
  input  logic    r_valid_i,
  input  r_chan_t r_i,
  output logic    r_ready_o,

  input  logic    b_valid_i,
  input  b_chan_t b_i,
  output logic    b_ready_o,

  input  logic    per_r_ready_i,
  output logic    per_r_valid_o,
  output per_id_t per_r_id_o,
  output data_t   per_r_rdata_o
);

  always_comb begin
    per_r_valid_o = 1'b0;
    per_r_id_o    = '0;
    per_r_rdata_o = '0;
    r_ready_o     = per_r_ready_i;
    b_ready_o     = per_r_ready_i;
    if (per_r_ready_i && r_valid_i) begin
      per_r_valid_o = 1'b1;
      per_r_id_o    = per_id_t'(r_i.id);  // Zero-extended
      per_r_rdata_o = r_i.data;
      b_ready_o     = 1'b0;               // Hold write response
    end else if (per_r_ready_i && b_valid_i) begin
      // Write completion carries no data
      per_r_valid_o = 1'b1;
      per_r_id_o    = per_id_t'(b_i.id);
    end
  end

endmodule

// File: design/per2axi_stream_fifo.sv
`timescale 1ns/1ps

module per2axi_stream_fifo #(
  parameter int unsigned DEPTH     = 2,
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  localparam int unsigned         PtrWidth = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PtrWidth-1:0] LastIdx  = PtrWidth'(DEPTH - 1);
  localparam logic [PtrWidth:0]   FullCnt  = (PtrWidth + 1)'(DEPTH);

  payload_t            mem_q [DEPTH];
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth:0]   count_q;
  logic                empty;
  logic                push;
  logic                pop;
  logic                bypass;
  logic                store;
  logic                fetch;

  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == LastIdx) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty   = (count_q == '0);
  assign ready_o = (count_q != FullCnt);
  assign valid_o = ~empty | valid_i;            // Fall-through when empty
  assign data_o  = empty ? data_i : mem_q[rd_ptr_q];

  assign push   = valid_i & ready_o;
  assign pop    = valid_o & ready_i;
  assign bypass = empty & push & pop;           // Beat never touches storage
  assign store  = push & ~bypass;
  assign fetch  = pop & ~empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (store) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (fetch) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({store, fetch})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (store) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: design/per2axi_top.sv
`timescale 1ns/1ps

`include "per2axi_config.svh"

module per2axi_top
  import per2axi_axi_pkg::*;
  import per2axi_per_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,

  input  logic    per_req_i,
  input  addr_t   per_add_i,
  input  logic    per_wen_i,
  input  data_t   per_wdata_i,
  input  strb_t   per_be_i,
  input  per_id_t per_id_i,
  output logic    per_gnt_o,

  output logic    per_r_valid_o,
  output per_id_t per_r_id_o,
  output data_t   per_r_rdata_o,
  input  logic    per_r_ready_i,

  output logic    aw_valid_o,
  output addr_t   aw_addr_o,
  output axi_id_t aw_id_o,
  input  logic    aw_ready_i,

  output logic    ar_valid_o,
  output addr_t   ar_addr_o,
  output axi_id_t ar_id_o,
  input  logic    ar_ready_i,

  output logic    w_valid_o,
  output data_t   w_data_o,
  output strb_t   w_strb_o,
  input  logic    w_ready_i,

  input  logic    r_valid_i,
  input  data_t   r_data_i,
  input  axi_id_t r_id_i,
  input  logic    r_last_i,
  output logic    r_ready_o,

  input  logic    b_valid_i,
  input  axi_id_t b_id_i,
  output logic    b_ready_o,

  output logic    busy_o
);

  // ========================================================================
  // Internal channels, bridge side of the FIFOs
  // ========================================================================

  logic     aw_valid, aw_ready, ar_valid, ar_ready, w_valid, w_ready;
  logic     r_valid, r_ready, b_valid, b_ready;
  ax_chan_t aw_in, aw_out, ar_in, ar_out;
  w_chan_t  w_in, w_out;
  r_chan_t  r_in, r_out;
  b_chan_t  b_in, b_out;

  per2axi_req_channel req_channel_i (
    .per_req_i   (per_req_i),
    .per_add_i   (per_add_i),
    .per_wen_i   (per_wen_i),
    .per_wdata_i (per_wdata_i),
    .per_be_i    (per_be_i),
    .per_id_i    (per_id_i),
    .per_gnt_o   (per_gnt_o),
    .aw_valid_o  (aw_valid),
    .aw_o        (aw_in),
    .aw_ready_i  (aw_ready),
    .ar_valid_o  (ar_valid),
    .ar_o        (ar_in),
    .ar_ready_i  (ar_ready),
    .w_valid_o   (w_valid),
    .w_o         (w_in),
    .w_ready_i   (w_ready)
  );

  per2axi_res_channel res_channel_i (
    .r_valid_i     (r_valid),
    .r_i           (r_out),
    .r_ready_o     (r_ready),
    .b_valid_i     (b_valid),
    .b_i           (b_out),
    .b_ready_o     (b_ready),
    .per_r_ready_i (per_r_ready_i),
    .per_r_valid_o (per_r_valid_o),
    .per_r_id_o    (per_r_id_o),
    .per_r_rdata_o (per_r_rdata_o)
  );

  per2axi_busy_unit busy_unit_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .aw_sync_i (aw_valid & aw_ready),
    .b_sync_i  (b_valid & b_ready),
    .ar_sync_i (ar_valid & ar_ready),
    .r_sync_i  (r_valid & r_ready & r_out.last),  // Last beat retires a read
    .busy_o    (busy_o)
  );

  // ========================================================================
  // Channel FIFOs
  // ========================================================================

  per2axi_stream_fifo #(.DEPTH(`PER2AXI_REQ_BUF_DEPTH), .payload_t(ax_chan_t)) aw_fifo_i (
    .clk_i, .rst_ni, .valid_i(aw_valid), .ready_o(aw_ready), .data_i(aw_in),
    .valid_o(aw_valid_o), .ready_i(aw_ready_i), .data_o(aw_out)
  );

  per2axi_stream_fifo #(.DEPTH(`PER2AXI_REQ_BUF_DEPTH), .payload_t(ax_chan_t)) ar_fifo_i (
    .clk_i, .rst_ni, .valid_i(ar_valid), .ready_o(ar_ready), .data_i(ar_in),
    .valid_o(ar_valid_o), .ready_i(ar_ready_i), .data_o(ar_out)
  );

  per2axi_stream_fifo #(.DEPTH(`PER2AXI_REQ_BUF_DEPTH), .payload_t(w_chan_t)) w_fifo_i (
    .clk_i, .rst_ni, .valid_i(w_valid), .ready_o(w_ready), .data_i(w_in),
    .valid_o(w_valid_o), .ready_i(w_ready_i), .data_o(w_out)
  );

  per2axi_stream_fifo #(.DEPTH(`PER2AXI_RSP_BUF_DEPTH), .payload_t(r_chan_t)) r_fifo_i (
    .clk_i, .rst_ni, .valid_i(r_valid_i), .ready_o(r_ready_o), .data_i(r_in),
    .valid_o(r_valid), .ready_i(r_ready), .data_o(r_out)
  );

  per2axi_stream_fifo #(.DEPTH(`PER2AXI_RSP_BUF_DEPTH), .payload_t(b_chan_t)) b_fifo_i (
    .clk_i, .rst_ni, .valid_i(b_valid_i), .ready_o(b_ready_o), .data_i(b_in),
    .valid_o(b_valid), .ready_i(b_ready), .data_o(b_out)
  );

  assign aw_addr_o = aw_out.addr;
  assign aw_id_o   = aw_out.id;
  assign ar_addr_o = ar_out.addr;
  assign ar_id_o   = ar_out.id;
  assign w_data_o  = w_out.data;
  assign w_strb_o  = w_out.strb;

  assign r_in.data = r_data_i;
  assign r_in.id   = r_id_i;
  assign r_in.last = r_last_i;
  assign b_in.id   = b_id_i;

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 10,
  parameter int unsigned RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_no = 1'b1;   // Released off the edge
  end

endmodule

// File: dv/tb_per2axi_top.sv
`timescale 1ns/1ps

`include "per2axi_config.svh"

module tb_per2axi_top
  import per2axi_axi_pkg::*;
  import per2axi_per_pkg::*;
();

  localparam int unsigned NumReads  = 8;
  localparam int unsigned NumWrites = 8;
  localparam int unsigned ReqDepth  = `PER2AXI_REQ_BUF_DEPTH;
  localparam int unsigned TotalReqs = NumReads + NumWrites + ReqDepth + 2 + 2;
  localparam int unsigned IdPad     = `PER2AXI_PER_ID_WIDTH - `PER2AXI_AXI_ID_WIDTH;

  typedef struct packed {
    data_t   data;
    per_id_t id;
  } rsp_t;

  typedef struct packed {
    ax_chan_t ax;
    w_chan_t  w;
    rsp_t     rsp;
  } exp_t;

  logic    clk, rst_n;
  logic    per_req, per_wen, per_gnt, per_r_valid, per_r_ready;
  addr_t   per_add;
  data_t   per_wdata, per_r_rdata;
  strb_t   per_be;
  per_id_t per_id, per_r_id;
  logic    aw_valid, aw_ready, ar_valid, ar_ready, w_valid, w_ready;
  addr_t   aw_addr, ar_addr;
  axi_id_t aw_id, ar_id, r_id, b_id;
  data_t   w_data, r_data;
  strb_t   w_strb;
  logic    r_valid, r_last, r_ready, b_valid, b_ready, busy;

  ax_chan_t exp_ar_q[$];
  ax_chan_t exp_aw_q[$];
  w_chan_t  exp_w_q[$];
  rsp_t     exp_rsp_q[$];
  addr_t    rd_addr_q[$];   // Slave side, reads to answer
  axi_id_t  rd_id_q[$];
  axi_id_t  wr_id_q[$];
  int       w_pending, r_sent, b_sent;
  string    test_name;
  int       test_errs, total_errs, test_cnt, fail_cnt;

  tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(5)) clk_gen_i (.clk_o(clk), .rst_no(rst_n));

  per2axi_top dut_i (
    .clk_i(clk), .rst_ni(rst_n), .busy_o(busy),
    .per_req_i(per_req), .per_add_i(per_add), .per_wen_i(per_wen),
    .per_wdata_i(per_wdata), .per_be_i(per_be), .per_id_i(per_id), .per_gnt_o(per_gnt),
    .per_r_valid_o(per_r_valid), .per_r_id_o(per_r_id), .per_r_rdata_o(per_r_rdata),
    .per_r_ready_i(per_r_ready),
    .aw_valid_o(aw_valid), .aw_addr_o(aw_addr), .aw_id_o(aw_id), .aw_ready_i(aw_ready),
    .ar_valid_o(ar_valid), .ar_addr_o(ar_addr), .ar_id_o(ar_id), .ar_ready_i(ar_ready),
    .w_valid_o(w_valid), .w_data_o(w_data), .w_strb_o(w_strb), .w_ready_i(w_ready),
    .r_valid_i(r_valid), .r_data_i(r_data), .r_id_i(r_id), .r_last_i(r_last),
    .r_ready_o(r_ready),
    .b_valid_i(b_valid), .b_id_i(b_id), .b_ready_o(b_ready)
  );

  // ========================================================================
  // Reference model and checks
  // ========================================================================

  // Slave memory contents
  function automatic data_t read_word(addr_t addr);
    return {addr ^ 32'h5a3c_96e1, ~addr};
  endfunction

  function automatic exp_t expected_beats(logic wen, addr_t addr, data_t wdata, strb_t be,
                                          per_id_t id);
    exp_t e;
    e.ax.addr  = addr;
    e.ax.id    = id[`PER2AXI_AXI_ID_WIDTH-1:0];   // Truncated on the way in
    e.w.data   = wdata;
    e.w.strb   = be;
    e.rsp.id   = {{IdPad{1'b0}}, e.ax.id};
    e.rsp.data = wen ? read_word(addr) : '0;      // Write completion has no data
    return e;
  endfunction

  task automatic check_ax(string what, ax_chan_t expected, ax_chan_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: %s expected %h, actual %h", test_name, what, expected, actual);
      test_errs++;
    end
  endtask

  task automatic check_w(string what, w_chan_t expected, w_chan_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: %s expected %h, actual %h", test_name, what, expected, actual);
      test_errs++;
    end
  endtask

  task automatic check_rsp(string what, data_t exp_data, per_id_t exp_id, data_t act_data,
                           per_id_t act_id);
    if ({act_data, act_id} !== {exp_data, exp_id}) begin
      $display("[ERROR] %s: %s expected %h/%h, actual %h/%h", test_name, what,
               exp_data, exp_id, act_data, act_id);
      test_errs++;
    end
  endtask

  task automatic check_bit(string what, logic expected, logic actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: %s expected %b, actual %b", test_name, what, expected, actual);
      test_errs++;
    end
  endtask

  task automatic report_stray(string chan);
    $display("%s: %s beat seen with nothing expected", test_name, chan);
    test_errs++;
  endtask

  // Beat monitor, every handshake against the expectation queues
  always @(posedge clk) begin
    if (rst_n && ar_valid && ar_ready) begin
      if (exp_ar_q.size() == 0) begin
        report_stray("AR");
      end else begin
        check_ax("ar", exp_ar_q.pop_front(), {ar_addr, ar_id});
      end
    end
    if (rst_n && aw_valid && aw_ready) begin
      if (exp_aw_q.size() == 0) begin
        report_stray("AW");
      end else begin
        check_ax("aw", exp_aw_q.pop_front(), {aw_addr, aw_id});
      end
    end
    if (rst_n && w_valid && w_ready) begin
      if (exp_w_q.size() == 0) begin
        report_stray("W");
      end else begin
        check_w("w", exp_w_q.pop_front(), {w_data, w_strb});
      end
    end
    if (rst_n && per_r_valid) begin   // Valid only while ready
      if (exp_rsp_q.size() == 0) begin
        report_stray("response");
      end else begin
        check_rsp("rsp", exp_rsp_q[0].data, exp_rsp_q[0].id, per_r_rdata, per_r_id);
        exp_rsp_q.delete(0);
      end
    end
  end

  // ========================================================================
  // AXI slave model
  // ========================================================================

  always @(posedge clk) begin : slave
    logic r_done;
    logic b_done;
    r_done = rst_n && r_valid && r_ready;
    b_done = rst_n && b_valid && b_ready;
    if (rst_n && ar_valid && ar_ready) begin
      rd_addr_q.push_back(ar_addr);
      rd_id_q.push_back(ar_id);
    end
    if (rst_n && aw_valid && aw_ready) begin
      wr_id_q.push_back(aw_id);
    end
    if (rst_n && w_valid && w_ready) begin
      w_pending++;
    end
    if (r_done) begin
      r_sent++;
    end
    if (b_done) begin
      b_sent++;
    end
    #1;
    if (r_done) begin
      r_valid = 1'b0;
    end
    if (!r_valid && rd_addr_q.size() != 0) begin
      r_valid = 1'b1;
      r_data  = read_word(rd_addr_q.pop_front());
      r_id    = rd_id_q.pop_front();
    end
    if (b_done) begin
      b_valid = 1'b0;
    end
    if (!b_valid && wr_id_q.size() != 0 && w_pending != 0) begin   // AW and W both seen
      b_valid = 1'b1;
      b_id    = wr_id_q.pop_front();
      w_pending--;
    end
  end

  // ========================================================================
  // Stimulus
  // ========================================================================

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic issue(logic wen, addr_t addr, data_t wdata, strb_t be, per_id_t id);
    exp_t e;
    e = expected_beats(wen, addr, wdata, be, id);
    while (!per_gnt) begin
      next_cycle();
    end
    per_req   = 1'b1;
    per_wen   = wen;
    per_add   = addr;
    per_wdata = wdata;
    per_be    = be;
    per_id    = id;
    if (wen) begin
      exp_ar_q.push_back(e.ax);
    end else begin
      exp_aw_q.push_back(e.ax);
      exp_w_q.push_back(e.w);
    end
    exp_rsp_q.push_back(e.rsp);
    next_cycle();
    per_req = 1'b0;
  endtask

  task automatic random_issue(logic wen);
    issue(wen, addr_t'($urandom), {$urandom, $urandom}, strb_t'($urandom),
          per_id_t'($urandom));
  endtask

  task automatic wait_drain();
    while (exp_ar_q.size() + exp_aw_q.size() + exp_w_q.size() + exp_rsp_q.size() != 0) begin
      next_cycle();
    end
    next_cycle();
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      $display("PASS  %s", test_name);
    end else begin
      $display("FAIL  %s (%0d errors)", test_name, test_errs);
      fail_cnt++;
    end
    total_errs += test_errs;
    test_cnt++;
  endtask

  initial begin
    int   accepted;
    int   r_base;
    int   b_base;
    rsp_t first_rsp;
    per_req     = 1'b0;
    per_wen     = 1'b1;
    per_add     = '0;
    per_wdata   = '0;
    per_be      = '0;
    per_id      = '0;
    per_r_ready = 1'b1;
    aw_ready    = 1'b1;
    ar_ready    = 1'b1;
    w_ready     = 1'b1;
    r_valid     = 1'b0;
    r_data      = '0;
    r_id        = '0;
    r_last      = 1'b1;   // Single-beat reads
    b_valid     = 1'b0;
    b_id        = '0;
    w_pending   = 0;
    r_sent      = 0;
    b_sent      = 0;
    test_errs   = 0;
    total_errs  = 0;
    test_cnt    = 0;
    fail_cnt    = 0;
    test_name   = "reset";
    void'($urandom(32'hf15519ef));
    wait (rst_n === 1'b1);
    next_cycle();

    start_test("reset");
    check_bit("ar_valid", 1'b0, ar_valid);
    check_bit("aw_valid", 1'b0, aw_valid);
    check_bit("w_valid", 1'b0, w_valid);
    check_bit("per_r_valid", 1'b0, per_r_valid);
    check_bit("busy", 1'b0, busy);
    check_bit("gnt", 1'b1, per_gnt);
    check_bit("r_ready", 1'b1, r_ready);   // Response FIFOs empty
    check_bit("b_ready", 1'b1, b_ready);
    end_test();

    start_test("reads");
    for (int i = 0; i < NumReads; i++) begin
      random_issue(1'b1);
      if (i == 0) begin
        check_bit("busy with read outstanding", 1'b1, busy);
      end
    end
    wait_drain();
    check_bit("busy after reads", 1'b0, busy);
    end_test();

    start_test("writes");
    for (int i = 0; i < NumWrites; i++) begin
      random_issue(1'b0);
      if (i == 0) begin
        check_bit("busy with write outstanding", 1'b1, busy);
      end
    end
    wait_drain();
    check_bit("busy after writes", 1'b0, busy);
    end_test();

    start_test("aw back-pressure");
    aw_ready = 1'b0;
    accepted = 0;
    while (per_gnt && accepted < ReqDepth + 2) begin
      random_issue(1'b0);
      accepted++;
    end
    check_bit("gnt with aw stalled", 1'b0, per_gnt);
    if (accepted > ReqDepth) begin
      $display("%s: %0d writes accepted into a queue of %0d", test_name, accepted, ReqDepth);
      test_errs++;
    end
    aw_ready = 1'b1;
    wait_drain();
    check_bit("gnt after release", 1'b1, per_gnt);
    end_test();

    start_test("r over b priority");
    per_r_ready = 1'b0;
    r_base      = r_sent;
    b_base      = b_sent;
    random_issue(1'b0);
    random_issue(1'b1);
    while (r_sent == r_base || b_sent == b_base) begin
      next_cycle();
    end
    check_bit("per_r_valid while not ready", 1'b0, per_r_valid);
    first_rsp = exp_rsp_q.pop_front();   // Read overtakes the earlier write
    exp_rsp_q.push_back(first_rsp);
    per_r_ready = 1'b1;
    wait_drain();
    end_test();

    $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, total_errs);
    if (total_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (50 * TotalReqs + 200) @(posedge clk);
    $display("Simulation stopped after %0d cycles without finishing", 50 * TotalReqs + 200);
    $display("Test failed");
    $finish;
  end

endmodule

// File: per2axi_top.f
+incdir+design
design/per2axi_axi_pkg.sv
design/per2axi_per_pkg.sv
design/per2axi_stream_fifo.sv
design/per2axi_req_channel.sv
design/per2axi_res_channel.sv
design/per2axi_busy_unit.sv
design/per2axi_top.sv
dv/tb_clk_gen.sv
dv/tb_per2axi_top.sv
